// ==== axi_ser_pkg.sv ====
/*
 * Shared definitions of the reduced AXI4 scratch subsystem.
 * Widths, single-beat channel payloads and the atomic encoding.
 */
package axi_ser_pkg;

  // Link widths
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 8;
  localparam int unsigned DataWidth = 32;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // Atomic kind carried with a write request
  typedef logic atop_t;
  localparam atop_t AtopNone = 1'b0;
  // Add, old value returned on R
  localparam atop_t AtopAdd  = 1'b1;

  // Address and data travel together, always one beat
  typedef struct packed {
    id_t   id;
    addr_t addr;
    data_t data;
    atop_t atomic;
  } wreq_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
  } areq_t;

  typedef struct packed {
    id_t  id;
    logic ok;
  } bresp_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    logic  last;
  } rresp_t;

endpackage

// ==== axi_ser_if.sv ====
/*
 * One reduced AXI4 link.
 * Write request, read request, write response and read response,
 * each with its own valid/ready pair.
 */
interface axi_ser_if;
  import axi_ser_pkg::*;

  // Write request, address and data in one beat
  wreq_t  wreq;
  logic   wreq_valid;
  logic   wreq_ready;

  // Read request
  areq_t  areq;
  logic   areq_valid;
  logic   areq_ready;

  // Write response
  bresp_t bresp;
  logic   b_valid;
  logic   b_ready;

  // Read response
  rresp_t rresp;
  logic   r_valid;
  logic   r_ready;

  // Requester side
  modport mst (
    output wreq, wreq_valid,
    input  wreq_ready,
    output areq, areq_valid,
    input  areq_ready,
    input  bresp, b_valid,
    output b_ready,
    input  rresp, r_valid,
    output r_ready
  );

  // Responder side
  modport slv (
    input  wreq, wreq_valid,
    output wreq_ready,
    input  areq, areq_valid,
    output areq_ready,
    output bresp, b_valid,
    input  b_ready,
    output rresp, r_valid,
    input  r_ready
  );

endinterface

// ==== id_fifo.sv ====
/*
 * Synchronous circular FIFO for IDs and port indices.
 * Head shown from storage, no fall-through.
 */
module id_fifo #(
  parameter int unsigned Depth  = 4,
  parameter type         item_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  push_i,
  input  item_t data_i,
  input  logic  pop_i,
  output item_t data_o,
  output logic  full_o,
  output logic  empty_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  item_t           mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            push_ok, pop_ok;

  assign full_o  = (cnt_q == CntW'(Depth));
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  // Ignore requests that would corrupt the buffer
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(push_ok) - CntW'(pop_ok);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // The owner must gate its push and pop with the flags
  a_no_overflow : assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> !full_o) else $error("id_fifo push while full");
  a_no_underflow : assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !empty_o) else $error("id_fifo pop while empty");

endmodule

// ==== axi_id_serializer.sv ====
/*
 * Per-port ID serializer.
 * Forwards every request with ID zero and restores the requester ID
 * on each response from in-order queues. Atomics wait for a full drain.
 */
module axi_id_serializer #(
  parameter int unsigned MaxReadTxns  = 4,
  parameter int unsigned MaxWriteTxns = 4
) (
  input logic    clk_i,
  input logic    rst_i,
  axi_ser_if.slv slv,
  axi_ser_if.mst mst
);
  import axi_ser_pkg::*;

  typedef enum logic [1:0] {
    SerIdle  = 2'b00,
    SerDrain = 2'b01,
    SerExec  = 2'b10
  } state_e;

  state_e state_q, state_d;
  logic   rd_full, rd_empty, rd_push, rd_pop;
  logic   wr_full, wr_empty, wr_push, wr_pop;
  id_t    rd_push_id, r_id, b_id;

  // Queue pops follow the upstream response handshakes
  assign wr_pop = mst.b_valid & slv.b_ready & ~wr_empty;
  assign rd_pop = mst.r_valid & slv.r_ready & ~rd_empty & mst.rresp.last;

  always_comb begin
    state_d    = state_q;
    rd_push    = 1'b0;
    wr_push    = 1'b0;
    rd_push_id = slv.areq.id;

    // Payloads pass with IDs tied to zero downstream
    mst.wreq    = slv.wreq;
    mst.wreq.id = '0;
    mst.areq    = slv.areq;
    mst.areq.id = '0;

    // Handshakes cut unless opened below
    mst.wreq_valid = 1'b0;
    slv.wreq_ready = 1'b0;
    mst.areq_valid = 1'b0;
    slv.areq_ready = 1'b0;

    case (state_q)
      SerIdle, SerExec: begin
        // Atomic done once both its responses have left
        if (state_q == SerExec && (wr_empty || wr_pop) && (rd_empty || rd_pop)) begin
          state_d = SerIdle;
        end
        if (state_d == SerIdle) begin
          // Reads gated by room in the read queue
          mst.areq_valid = slv.areq_valid & ~rd_full;
          slv.areq_ready = mst.areq_ready & ~rd_full;
          rd_push        = mst.areq_valid & mst.areq_ready;
          if (slv.wreq_valid) begin
            if (slv.wreq.atomic == AtopNone) begin
              mst.wreq_valid = ~wr_full;
              slv.wreq_ready = mst.wreq_ready & ~wr_full;
              wr_push        = mst.wreq_valid & mst.wreq_ready;
            end else if (!mst.areq_valid || mst.areq_ready) begin
              // No read left half-issued when draining starts
              state_d = SerDrain;
            end
          end
        end
      end
      SerDrain: begin
        // Issue the atomic after the last open transaction
        if (wr_empty && rd_empty) begin
          mst.wreq_valid = 1'b1;
          slv.wreq_ready = mst.wreq_ready;
          wr_push        = mst.wreq_ready;
          // Atomic also answers on R with its own ID
          rd_push_id     = slv.wreq.id;
          rd_push        = mst.wreq_ready;
          if (mst.wreq_ready) begin
            state_d = SerExec;
          end
        end
      end
      default: state_d = SerIdle;
    endcase
  end

  // Responses only pass with a queued ID to restore
  assign slv.b_valid = mst.b_valid & ~wr_empty;
  assign mst.b_ready = slv.b_ready & ~wr_empty;
  assign slv.r_valid = mst.r_valid & ~rd_empty;
  assign mst.r_ready = slv.r_ready & ~rd_empty;

  always_comb begin
    slv.bresp    = mst.bresp;
    slv.bresp.id = b_id;
    slv.rresp    = mst.rresp;
    slv.rresp.id = r_id;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= SerIdle;
    end else begin
      state_q <= state_d;
    end
  end

  id_fifo #(
    .Depth  (MaxReadTxns),
    .item_t (id_t)
  ) i_rd_ids (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (rd_push),
    .data_i  (rd_push_id),
    .pop_i   (rd_pop),
    .data_o  (r_id),
    .full_o  (rd_full),
    .empty_o (rd_empty)
  );

  id_fifo #(
    .Depth  (MaxWriteTxns),
    .item_t (id_t)
  ) i_wr_ids (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (wr_push),
    .data_i  (slv.wreq.id),
    .pop_i   (wr_pop),
    .data_o  (b_id),
    .full_o  (wr_full),
    .empty_o (wr_empty)
  );

  // A request offered downstream stays offered until it is taken
  a_wreq_held : assert property (@(posedge clk_i) disable iff (rst_i)
    mst.wreq_valid & ~mst.wreq_ready |=> mst.wreq_valid)
    else $error("write request withdrawn before its handshake");
  a_areq_held : assert property (@(posedge clk_i) disable iff (rst_i)
    mst.areq_valid & ~mst.areq_ready |=> mst.areq_valid)
    else $error("read request withdrawn before its handshake");
  // Every response from below finds a queued ID to carry it upstream
  a_b_has_id : assert property (@(posedge clk_i) disable iff (rst_i)
    mst.b_valid |-> !wr_empty)
    else $error("write response without a queued ID");
  a_r_has_id : assert property (@(posedge clk_i) disable iff (rst_i)
    mst.r_valid |-> !rd_empty)
    else $error("read response without a queued ID");

endmodule

// ==== axi_port_arbiter.sv ====
/*
 * Round-robin merge of the serialized ports onto one link.
 * Order FIFOs remember the source port of each transaction for routing back.
 */
module axi_port_arbiter #(
  parameter int unsigned NumPorts     = 3,
  parameter int unsigned MaxReadTxns  = 4,
  parameter int unsigned MaxWriteTxns = 4
) (
  input logic    clk_i,
  input logic    rst_i,
  axi_ser_if.slv up [NumPorts],
  axi_ser_if.mst dn
);
  import axi_ser_pkg::*;

  localparam int unsigned IdxW = (NumPorts > 1) ? $clog2(NumPorts) : 1;
  typedef logic [IdxW-1:0] idx_t;

  // Flattened port signals, indexable at run time
  wreq_t               wreq_a [NumPorts];
  areq_t               areq_a [NumPorts];
  logic [NumPorts-1:0] wreq_v, areq_v, b_rdy, r_rdy;
  logic [NumPorts-1:0] wreq_rdy, areq_rdy, b_vld, r_vld;

  idx_t wr_ptr_q, rd_ptr_q, wr_sel, rd_sel, b_head, r_head, r_push_idx;
  logic wr_atomic, wr_go, rd_go, wr_hs, rd_hs;
  logic b_full, b_empty, b_pop, r_full, r_empty, r_push, r_pop;

  for (genvar i = 0; i < NumPorts; i++) begin : g_port
    assign wreq_a[i]         = up[i].wreq;
    assign wreq_v[i]         = up[i].wreq_valid;
    assign areq_a[i]         = up[i].areq;
    assign areq_v[i]         = up[i].areq_valid;
    assign b_rdy[i]          = up[i].b_ready;
    assign r_rdy[i]          = up[i].r_ready;
    assign up[i].wreq_ready  = wreq_rdy[i];
    assign up[i].areq_ready  = areq_rdy[i];
    // Payloads broadcast, only the owner sees valid
    assign up[i].bresp       = dn.bresp;
    assign up[i].b_valid     = b_vld[i];
    assign up[i].rresp       = dn.rresp;
    assign up[i].r_valid     = r_vld[i];
  end

  // First requester at or after the pointer
  function automatic idx_t rr_pick(input logic [NumPorts-1:0] req, input idx_t ptr);
    idx_t pick;
    int   cand;
    pick = ptr;
    for (int k = NumPorts - 1; k >= 0; k--) begin
      cand = (int'(ptr) + k) % int'(NumPorts);
      if (req[cand]) pick = idx_t'(cand);
    end
    return pick;
  endfunction

  function automatic idx_t next_idx(input idx_t idx);
    return (idx == idx_t'(NumPorts - 1)) ? '0 : idx + 1'b1;
  endfunction

  always_comb begin
    wr_sel    = rr_pick(wreq_v, wr_ptr_q);
    rd_sel    = rr_pick(areq_v, rd_ptr_q);
    wr_atomic = (wreq_a[wr_sel].atomic == AtopAdd);
    // An atomic needs room in both order FIFOs
    wr_go     = |wreq_v & ~b_full & ~(wr_atomic & r_full);
    // Read waits when an atomic claims the R order slot
    rd_go     = |areq_v & ~r_full & ~(wr_go & wr_atomic);

    dn.wreq        = wreq_a[wr_sel];
    dn.wreq_valid  = wr_go;
    dn.areq        = areq_a[rd_sel];
    dn.areq_valid  = rd_go;
    wreq_rdy       = '0;
    areq_rdy       = '0;
    wreq_rdy[wr_sel] = wr_go & dn.wreq_ready;
    areq_rdy[rd_sel] = rd_go & dn.areq_ready;

    wr_hs      = wr_go & dn.wreq_ready;
    rd_hs      = rd_go & dn.areq_ready;
    r_push     = rd_hs | (wr_hs & wr_atomic);
    r_push_idx = rd_hs ? rd_sel : wr_sel;
  end

  // Responses steered to the oldest open port
  always_comb begin
    b_vld         = '0;
    r_vld         = '0;
    b_vld[b_head] = dn.b_valid & ~b_empty;
    r_vld[r_head] = dn.r_valid & ~r_empty;
    dn.b_ready    = b_rdy[b_head] & ~b_empty;
    dn.r_ready    = r_rdy[r_head] & ~r_empty;
    b_pop         = dn.b_valid & dn.b_ready;
    r_pop         = dn.r_valid & dn.r_ready & dn.rresp.last;
  end

  // Pointers step past each granted port
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_hs) wr_ptr_q <= next_idx(wr_sel);
      if (rd_hs) rd_ptr_q <= next_idx(rd_sel);
    end
  end

  id_fifo #(
    .Depth  (NumPorts * MaxWriteTxns),
    .item_t (idx_t)
  ) i_b_order (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (wr_hs),
    .data_i  (wr_sel),
    .pop_i   (b_pop),
    .data_o  (b_head),
    .full_o  (b_full),
    .empty_o (b_empty)
  );

  id_fifo #(
    .Depth  (NumPorts * MaxReadTxns),
    .item_t (idx_t)
  ) i_r_order (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (r_push),
    .data_i  (r_push_idx),
    .pop_i   (r_pop),
    .data_o  (r_head),
    .full_o  (r_full),
    .empty_o (r_empty)
  );

  // The memory never answers a request that was not granted here
  a_b_has_owner : assert property (@(posedge clk_i) disable iff (rst_i)
    dn.b_valid |-> !b_empty) else $error("write response without owner port");
  a_r_has_owner : assert property (@(posedge clk_i) disable iff (rst_i)
    dn.r_valid |-> !r_empty) else $error("read response without owner port");

endmodule

// ==== axi_scratch_mem.sv ====
/*
 * In-order scratch memory slave, one beat per transfer.
 * Plain writes and reads, plus atomic add returning the old word.
 */
module axi_scratch_mem #(
  parameter int unsigned MemWords = 64
) (
  input logic    clk_i,
  input logic    rst_i,
  axi_ser_if.slv slv
);
  import axi_ser_pkg::*;

  localparam int unsigned IdxW = (MemWords > 1) ? $clog2(MemWords) : 1;

  data_t            mem_q [MemWords];
  data_t            r_data_q, w_old;
  logic [IdxW-1:0]  w_idx, a_idx;
  logic             b_valid_q, r_valid_q;
  logic             w_hs, a_hs, w_atomic;

  // Word index from the byte address
  assign w_idx    = slv.wreq.addr[IdxW+1:2];
  assign a_idx    = slv.areq.addr[IdxW+1:2];
  assign w_old    = mem_q[w_idx];
  assign w_atomic = (slv.wreq.atomic == AtopAdd);

  // New requests only with both response slots free
  assign slv.wreq_ready = ~b_valid_q & ~r_valid_q;
  // An atomic owns the R slot in its cycle
  assign slv.areq_ready = ~b_valid_q & ~r_valid_q & ~(slv.wreq_valid & w_atomic);

  assign w_hs = slv.wreq_valid & slv.wreq_ready;
  assign a_hs = slv.areq_valid & slv.areq_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (slv.b_valid && slv.b_ready) b_valid_q <= 1'b0;
      if (slv.r_valid && slv.r_ready) r_valid_q <= 1'b0;
      if (w_hs) b_valid_q <= 1'b1;
      if ((w_hs && w_atomic) || a_hs) r_valid_q <= 1'b1;
    end
  end

  // Storage and read data
  always_ff @(posedge clk_i) begin
    if (w_hs) begin
      mem_q[w_idx] <= w_atomic ? w_old + slv.wreq.data : slv.wreq.data;
    end
    if (w_hs && w_atomic) begin
      r_data_q <= w_old;
    end else if (a_hs) begin
      r_data_q <= mem_q[a_idx];
    end
  end

  // Responses leave with ID zero
  assign slv.b_valid    = b_valid_q;
  assign slv.bresp.id   = '0;
  assign slv.bresp.ok   = 1'b1;
  assign slv.r_valid    = r_valid_q;
  assign slv.rresp.id   = '0;
  assign slv.rresp.data = r_data_q;
  assign slv.rresp.last = 1'b1;

endmodule

// ==== axi_ser_top.sv ====
/*
 * Shared scratch memory subsystem.
 * One ID serializer per requester port, round-robin merge, one memory.
 */
module axi_ser_top #(
  parameter int unsigned NumPorts     = 3,
  parameter int unsigned MaxReadTxns  = 4,
  parameter int unsigned MaxWriteTxns = 4,
  parameter int unsigned MemWords     = 64
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  axi_ser_pkg::wreq_t  [NumPorts-1:0]    wreq_i,
  input  logic                [NumPorts-1:0]    wreq_valid_i,
  output logic                [NumPorts-1:0]    wreq_ready_o,
  input  axi_ser_pkg::areq_t  [NumPorts-1:0]    areq_i,
  input  logic                [NumPorts-1:0]    areq_valid_i,
  output logic                [NumPorts-1:0]    areq_ready_o,
  output axi_ser_pkg::bresp_t [NumPorts-1:0]    bresp_o,
  output logic                [NumPorts-1:0]    b_valid_o,
  input  logic                [NumPorts-1:0]    b_ready_i,
  output axi_ser_pkg::rresp_t [NumPorts-1:0]    rresp_o,
  output logic                [NumPorts-1:0]    r_valid_o,
  input  logic                [NumPorts-1:0]    r_ready_i
);

  // Requester links, serialized links, memory link
  axi_ser_if port_if [NumPorts] ();
  axi_ser_if ser_if  [NumPorts] ();
  axi_ser_if mem_if ();

  for (genvar i = 0; i < NumPorts; i++) begin : g_ser
    assign port_if[i].wreq       = wreq_i[i];
    assign port_if[i].wreq_valid = wreq_valid_i[i];
    assign wreq_ready_o[i]       = port_if[i].wreq_ready;
    assign port_if[i].areq       = areq_i[i];
    assign port_if[i].areq_valid = areq_valid_i[i];
    assign areq_ready_o[i]       = port_if[i].areq_ready;
    assign bresp_o[i]            = port_if[i].bresp;
    assign b_valid_o[i]          = port_if[i].b_valid;
    assign port_if[i].b_ready    = b_ready_i[i];
    assign rresp_o[i]            = port_if[i].rresp;
    assign r_valid_o[i]          = port_if[i].r_valid;
    assign port_if[i].r_ready    = r_ready_i[i];

    axi_id_serializer #(
      .MaxReadTxns  (MaxReadTxns),
      .MaxWriteTxns (MaxWriteTxns)
    ) i_serializer (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .slv   (port_if[i]),
      .mst   (ser_if[i])
    );
  end

  axi_port_arbiter #(
    .NumPorts     (NumPorts),
    .MaxReadTxns  (MaxReadTxns),
    .MaxWriteTxns (MaxWriteTxns)
  ) i_arbiter (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .up    (ser_if),
    .dn    (mem_if)
  );

  axi_scratch_mem #(
    .MemWords (MemWords)
  ) i_mem (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .slv   (mem_if)
  );

endmodule

// ==== tb_axi_ser_top.sv ====
/*
 * Testbench of the shared scratch memory subsystem.
 * Per-port request queues drive the DUT, a model memory predicts every
 * response and a compare process checks them in per-port order.
 */
module tb_axi_ser_top;
  timeunit 1ns;
  timeprecision 1ps;
  import axi_ser_pkg::*;

  localparam int unsigned NumPorts     = 3;
  localparam int unsigned MaxReadTxns  = 4;
  localparam int unsigned MaxWriteTxns = 4;
  localparam int unsigned MemWords     = 64;
  // Words owned by each port
  localparam int unsigned PortWords    = 16;
  localparam int          MaxCycles    = 4000;

  logic                   clk_i;
  logic                   rst_i;
  wreq_t  [NumPorts-1:0]  wreq_i;
  logic   [NumPorts-1:0]  wreq_valid_i, wreq_ready_o;
  areq_t  [NumPorts-1:0]  areq_i;
  logic   [NumPorts-1:0]  areq_valid_i, areq_ready_o;
  bresp_t [NumPorts-1:0]  bresp_o;
  logic   [NumPorts-1:0]  b_valid_o, b_ready_i;
  rresp_t [NumPorts-1:0]  rresp_o;
  logic   [NumPorts-1:0]  r_valid_o, r_ready_i;

  // Pending stimulus and expected responses, one queue per port
  wreq_t  wq    [NumPorts][$];
  areq_t  aq    [NumPorts][$];
  bresp_t exp_b [NumPorts][$];
  rresp_t exp_r [NumPorts][$];

  data_t  ref_mem [MemWords];
  integer seed;
  int     errors, checks, tests, cycles;
  logic   bp_en;
  int     b_len [NumPorts];
  int     r_len [NumPorts];
  logic   b_low [NumPorts];
  logic   r_low [NumPorts];

  axi_ser_top #(
    .NumPorts     (NumPorts),
    .MaxReadTxns  (MaxReadTxns),
    .MaxWriteTxns (MaxWriteTxns),
    .MemWords     (MemWords)
  ) UUT (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .wreq_i       (wreq_i),
    .wreq_valid_i (wreq_valid_i),
    .wreq_ready_o (wreq_ready_o),
    .areq_i       (areq_i),
    .areq_valid_i (areq_valid_i),
    .areq_ready_o (areq_ready_o),
    .bresp_o      (bresp_o),
    .b_valid_o    (b_valid_o),
    .b_ready_i    (b_ready_i),
    .rresp_o      (rresp_o),
    .r_valid_o    (r_valid_o),
    .r_ready_i    (r_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Model memory: a write stores, an atomic adds, both return the old word
  function automatic data_t ref_access(input addr_t addr, input data_t data,
                                       input logic wr, input logic add);
    data_t old;
    int    idx;
    idx = int'(addr >> 2) % MemWords;
    old = ref_mem[idx];
    if (wr) begin
      ref_mem[idx] = add ? old + data : data;
    end
    return old;
  endfunction

  // Ready level that stays put for a random number of cycles
  function automatic logic stretch_ready(inout int len, inout logic low);
    if (len == 0) begin
      len = 1 + ($random(seed) & 7);
      low = 1'($random(seed));
    end else begin
      len = len - 1;
    end
    return ~low;
  endfunction

  task automatic check_b(input string name, input bresp_t exp, input bresp_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_r(input string name, input rresp_t exp, input rresp_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_flags(input string name, input logic [NumPorts-1:0] exp,
                             input logic [NumPorts-1:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h got %h", name, exp, got);
    end
  endtask

  // Request drivers, payload held until the handshake edge
  always @(posedge clk_i) begin
    if (!rst_i) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (wreq_valid_i[p] && wreq_ready_o[p]) void'(wq[p].pop_front());
        if (areq_valid_i[p] && areq_ready_o[p]) void'(aq[p].pop_front());
        if (wq[p].size() > 0) begin
          wreq_i[p]       <= wq[p][0];
          wreq_valid_i[p] <= 1'b1;
        end else begin
          wreq_valid_i[p] <= 1'b0;
        end
        if (aq[p].size() > 0) begin
          areq_i[p]       <= aq[p][0];
          areq_valid_i[p] <= 1'b1;
        end else begin
          areq_valid_i[p] <= 1'b0;
        end
        // Response back-pressure
        if (bp_en) begin
          b_ready_i[p] <= stretch_ready(b_len[p], b_low[p]);
          r_ready_i[p] <= stretch_ready(r_len[p], r_low[p]);
        end else begin
          b_ready_i[p] <= 1'b1;
          r_ready_i[p] <= 1'b1;
        end
      end
    end
  end

  // Predict on request handshakes, compare on response handshakes
  always @(posedge clk_i) begin
    bresp_t eb;
    rresp_t er;
    data_t  old;
    if (!rst_i) begin
      // Reads first, a write in the same cycle lands after them
      for (int p = 0; p < NumPorts; p++) begin
        if (areq_valid_i[p] && areq_ready_o[p]) begin
          er.id   = areq_i[p].id;
          er.data = ref_access(areq_i[p].addr, '0, 1'b0, 1'b0);
          er.last = 1'b1;
          exp_r[p].push_back(er);
        end
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (wreq_valid_i[p] && wreq_ready_o[p]) begin
          old   = ref_access(wreq_i[p].addr, wreq_i[p].data, 1'b1,
                             wreq_i[p].atomic == AtopAdd);
          eb.id = wreq_i[p].id;
          eb.ok = 1'b1;
          exp_b[p].push_back(eb);
          // Atomic also answers on R with the old word
          if (wreq_i[p].atomic == AtopAdd) begin
            er.id   = wreq_i[p].id;
            er.data = old;
            er.last = 1'b1;
            exp_r[p].push_back(er);
          end
        end
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (b_valid_o[p] && b_ready_i[p]) begin
          if (exp_b[p].size() == 0) begin
            errors++;
            $display("Port %0d returned a write response with none outstanding", p);
          end else begin
            check_b($sformatf("bresp_o[%0d]", p), exp_b[p].pop_front(), bresp_o[p]);
          end
        end
        if (r_valid_o[p] && r_ready_i[p]) begin
          if (exp_r[p].size() == 0) begin
            errors++;
            $display("Port %0d returned a read response with none outstanding", p);
          end else begin
            check_r($sformatf("rresp_o[%0d]", p), exp_r[p].pop_front(), rresp_o[p]);
          end
        end
      end
    end
  end

  // Run limit, twice the cycles the tests need
  initial begin
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, responses still outstanding", cycles);
    $display("Regression failed");
    $finish;
  end

  // Byte address of word w in the range of port p
  function automatic addr_t port_addr(input int p, input int w);
    return addr_t'((p * PortWords + w) * 4);
  endfunction

  task automatic put_write(input int p, input id_t id, input addr_t addr,
                           input data_t data, input atop_t atomic);
    wreq_t req;
    req.id     = id;
    req.addr   = addr;
    req.data   = data;
    req.atomic = atomic;
    wq[p].push_back(req);
  endtask

  task automatic put_read(input int p, input id_t id, input addr_t addr);
    areq_t req;
    req.id   = id;
    req.addr = addr;
    aq[p].push_back(req);
  endtask

  task automatic random_ops(input int p, input int n, input bit with_atomic);
    int  w;
    int  kind;
    id_t id;
    for (int k = 0; k < n; k++) begin
      w    = $random(seed) & (PortWords - 1);
      kind = $random(seed) & 7;
      id   = id_t'($random(seed));
      if (with_atomic && kind == 0) begin
        put_write(p, id, port_addr(p, w), data_t'($random(seed) & 255), AtopAdd);
      end else if (kind < 4) begin
        put_write(p, id, port_addr(p, w), data_t'($random(seed)), AtopNone);
      end else begin
        put_read(p, id, port_addr(p, w));
      end
    end
  endtask

  function automatic logic all_idle();
    for (int p = 0; p < NumPorts; p++) begin
      if (wq[p].size() != 0 || aq[p].size() != 0) return 1'b0;
      if (exp_b[p].size() != 0 || exp_r[p].size() != 0) return 1'b0;
    end
    return (wreq_valid_i == '0) && (areq_valid_i == '0);
  endfunction

  // Until every request is sent and every response is back
  task automatic wait_idle();
    do begin
      @(negedge clk_i);
    end while (!all_idle());
  endtask

  task automatic finish_test(input string name, input int err0);
    tests++;
    $display("Test %0d %s: %s at cycle %0d", tests, name,
             (errors == err0) ? "ok" : "mismatches", cycles);
  endtask

  initial begin
    int err0;
    seed         = 95604;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    bp_en        = 1'b0;
    rst_i        = 1'b1;
    wreq_i       = '0;
    wreq_valid_i = '0;
    areq_i       = '0;
    areq_valid_i = '0;
    b_ready_i    = '1;
    r_ready_i    = '1;
    for (int p = 0; p < NumPorts; p++) begin
      b_len[p] = 0;
      r_len[p] = 0;
      b_low[p] = 1'b0;
      r_low[p] = 1'b0;
    end
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);

    // Quiet outputs straight after reset
    err0 = errors;
    check_flags("wreq_ready_o", '0, wreq_ready_o);
    check_flags("areq_ready_o", '0, areq_ready_o);
    check_flags("b_valid_o", '0, b_valid_o);
    check_flags("r_valid_o", '0, r_valid_o);
    finish_test("reset state", err0);

    err0 = errors;
    put_write(0, 4'h3, port_addr(0, 0), 32'hcafe_0001, AtopNone);
    wait_idle();
    put_read(0, 4'ha, port_addr(0, 0));
    wait_idle();
    finish_test("write then read", err0);

    // Back-to-back reads, each with its own ID
    err0 = errors;
    for (int k = 1; k <= MaxReadTxns; k++) begin
      put_write(0, id_t'(k), port_addr(0, k), data_t'($random(seed)), AtopNone);
    end
    wait_idle();
    for (int k = 1; k <= MaxReadTxns; k++) begin
      put_read(0, id_t'(k + 4), port_addr(0, k));
    end
    wait_idle();
    finish_test("outstanding reads", err0);

    // Fill every word, then mixed traffic on all ports at once
    err0 = errors;
    for (int p = 0; p < NumPorts; p++) begin
      for (int w = 0; w < PortWords; w++) begin
        put_write(p, id_t'($random(seed)), port_addr(p, w), data_t'($random(seed)), AtopNone);
      end
    end
    wait_idle();
    for (int p = 0; p < NumPorts; p++) begin
      random_ops(p, 24, 1'b0);
    end
    wait_idle();
    finish_test("random traffic", err0);

    // Atomic queued behind reads on the same port
    err0 = errors;
    for (int k = 0; k < 3; k++) begin
      put_read(1, id_t'(k + 1), port_addr(1, k));
    end
    put_write(1, 4'h9, port_addr(1, 5), 32'h0000_0010, AtopAdd);
    wait_idle();
    put_read(1, 4'hc, port_addr(1, 5));
    wait_idle();
    finish_test("atomic add", err0);

    err0 = errors;
    bp_en = 1'b1;
    for (int p = 0; p < NumPorts; p++) begin
      random_ops(p, 20, 1'b1);
    end
    wait_idle();
    bp_en = 1'b0;
    @(negedge clk_i);
    check_flags("b_valid_o", '0, b_valid_o);
    check_flags("r_valid_o", '0, r_valid_o);
    finish_test("response back-pressure", err0);

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== axi_ser_top.f ====
axi_ser_pkg.sv
axi_ser_if.sv
id_fifo.sv
axi_id_serializer.sv
axi_port_arbiter.sv
axi_scratch_mem.sv
axi_ser_top.sv
tb_axi_ser_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the regression with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_ser_top \
  -f axi_ser_top.f -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "Regression passed" && exit 0 || exit 1
